// ==== include/mainboard_config.svh ====
`ifndef MAINBOARD_CONFIG_SVH
`define MAINBOARD_CONFIG_SVH

`define MB_CPU_CLK_DIV   4    // clocks per cpu enable

`define MB_SCRATCH_WORDS 128

// cartridge geometry
`define MB_CROM_BANKS    4
`define MB_CROM_BYTES    256
`define MB_BANK_BITS     2

`endif

// ==== hdl/bus_pkg.sv ====
package bus_pkg;

   // map view of a cpu address
   typedef struct packed {
      logic [2:0] region;
      logic [2:0] page;
      logic [9:0] offset;
   } cpu_map_t;

   // bank view, used by writes into the cartridge window
   typedef struct packed {
      logic [2:0] region;
      logic [5:0] rsvd;
      logic [5:0] bank;
      logic       lsb;
   } cpu_bank_t;

   typedef union packed {
      cpu_map_t  map_v;
      cpu_bank_t bank_v;
   } cpu_addr_u;

   typedef struct packed {
      logic        memen;
      logic        we;
      cpu_addr_u   addr;
      logic [15:0] wdata;
   } cpu_bus_t;

   typedef enum logic [1:0] {REG_NONE, REG_SCRATCH, REG_CART} region_e;

endpackage

// ==== hdl/mem_pkg.sv ====
package mem_pkg;

   typedef struct packed {
      logic scratch;  // scratchpad access
      logic cart;     // cartridge read
      logic bank_wr;  // write into the cartridge window
   } dev_sel_t;

   // one byte cycle towards the 8-bit side
   typedef struct packed {
      logic        strobe;
      logic [15:0] addr;   // bit 0 picks the odd byte
   } byte_bus_t;

   typedef struct packed {
      logic [5:0] bank;
      logic [7:0] offset;
      logic [7:0] data;
   } crom_load_t;

endpackage

// ==== hdl/clk_enable_gen.sv ====
`timescale 1ns/10ps

`include "mainboard_config.svh"

module clk_enable_gen (
   input  logic clk,
   input  logic reset_i,
   output logic cpu_clk_en_o
);

   localparam int CNT_W = $clog2(`MB_CPU_CLK_DIV);

   logic [CNT_W-1:0] cnt_q;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         cnt_q        <= CNT_W'(`MB_CPU_CLK_DIV - 1);
         cpu_clk_en_o <= 1'b0;
      end else if (cnt_q == '0) begin
         cnt_q        <= CNT_W'(`MB_CPU_CLK_DIV - 1);  // reload
         cpu_clk_en_o <= 1'b1;
      end else begin
         cnt_q        <= cnt_q - 1'b1;
         cpu_clk_en_o <= 1'b0;
      end
   end

   // the bus FSM needs a gap between ready and the next enable
   a_div_min: assert property (@(posedge clk) `MB_CPU_CLK_DIV >= 2);

   a_en_single: assert property (@(posedge clk) disable iff (reset_i)
      cpu_clk_en_o |=> !cpu_clk_en_o);

endmodule

// ==== hdl/address_decoder.sv ====
`timescale 1ns/10ps

`include "mainboard_config.svh"

module address_decoder
   import bus_pkg::*;
   import mem_pkg::*;
(
   input  cpu_bus_t                 cpu_bus_i,
   output dev_sel_t                 sel_o,
   output region_e                  region_o,
   output logic [`MB_BANK_BITS-1:0] bank_o
);

   localparam logic [2:0] CART_REGION    = 3'd3;
   localparam logic [2:0] SCRATCH_REGION = 3'd4;

   cpu_map_t map;

   assign map = cpu_bus_i.addr.map_v;

   always_comb begin
      sel_o    = '0;
      region_o = REG_NONE;
      if (map.region == CART_REGION) begin
         if (cpu_bus_i.we) begin
            // bank select, completes like a fast access
            sel_o.bank_wr = cpu_bus_i.memen;
         end else begin
            sel_o.cart = cpu_bus_i.memen;
            region_o   = REG_CART;
         end
      end else if (map.region == SCRATCH_REGION && map.page == 3'd0) begin
         sel_o.scratch = cpu_bus_i.memen;
         region_o      = REG_SCRATCH;
      end
   end

   // bank number from the bank view, wrapped to the fitted banks
   assign bank_o = `MB_BANK_BITS'(cpu_bus_i.addr.bank_v.bank % `MB_CROM_BANKS);

endmodule

// ==== hdl/bus_multiplexer.sv ====
`timescale 1ns/10ps

module bus_multiplexer
   import bus_pkg::*;
   import mem_pkg::*;
(
   input  logic        clk,
   input  logic        reset_i,
   input  logic        cpu_clk_en_i,
   input  logic        memen_i,
   input  region_e     region_i,
   input  cpu_addr_u   addr_i,
   output byte_bus_t   byte_o,
   input  logic [7:0]  byte_data_i,
   output logic [15:0] word_o,
   output logic        word_valid_o,
   output logic        ready_o
);

   typedef enum logic [1:0] {IDLE, EVEN, ODD, DONE} state_e;

   state_e      state_q;
   logic        strobe_q;
   logic [15:0] byte_addr_q;
   logic [15:0] word_q;
   logic        word_valid_q;
   logic [15:0] even_addr;
   logic [15:0] odd_addr;

   assign even_addr = {addr_i.bank_v.region, addr_i.bank_v.rsvd, addr_i.bank_v.bank, 1'b0};
   assign odd_addr  = {addr_i.bank_v.region, addr_i.bank_v.rsvd, addr_i.bank_v.bank, 1'b1};

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state_q      <= IDLE;
         strobe_q     <= 1'b0;
         word_valid_q <= 1'b0;
      end else begin
         strobe_q     <= 1'b0;
         word_valid_q <= 1'b0;
         case (state_q)
            IDLE: begin
               if (cpu_clk_en_i && memen_i) begin
                  if (region_i == REG_CART) begin
                     state_q  <= EVEN;
                     strobe_q <= 1'b1;  // launch even byte
                  end else begin
                     state_q <= DONE;
                  end
               end
            end
            EVEN: begin
               if (cpu_clk_en_i) begin
                  state_q  <= ODD;
                  strobe_q <= 1'b1;
               end
            end
            ODD: begin
               if (cpu_clk_en_i) begin
                  state_q      <= DONE;
                  word_valid_q <= 1'b1;
               end
            end
            DONE: state_q <= IDLE;
            default: state_q <= IDLE;
         endcase
      end
   end

   // byte address and assembled word
   always_ff @(posedge clk) begin
      if (cpu_clk_en_i) begin
         case (state_q)
            IDLE: byte_addr_q <= even_addr;
            EVEN: begin
               byte_addr_q  <= odd_addr;
               word_q[15:8] <= byte_data_i;  // even byte is the high half
            end
            ODD: word_q[7:0] <= byte_data_i;
            default: ;
         endcase
      end
   end

   assign byte_o       = '{strobe: strobe_q, addr: byte_addr_q};
   assign word_o       = word_q;
   assign word_valid_o = word_valid_q;
   assign ready_o      = (state_q == DONE);

   a_strobe_state: assert property (@(posedge clk) disable iff (reset_i)
      strobe_q |-> (state_q inside {EVEN, ODD}));

   a_ready_pulse: assert property (@(posedge clk) disable iff (reset_i)
      ready_o |=> !ready_o);

endmodule

// ==== hdl/scratchpad_ram.sv ====
`timescale 1ns/10ps

`include "mainboard_config.svh"

module scratchpad_ram
   import bus_pkg::*;
(
   input  logic        clk,
   input  logic        cpu_clk_en_i,
   input  logic        sel_i,
   input  logic        we_i,
   input  cpu_addr_u   addr_i,
   input  logic [15:0] wdata_i,
   output logic [15:0] rdata_o
);

   localparam int IDX_W = $clog2(`MB_SCRATCH_WORDS);

   logic [15:0]      mem [`MB_SCRATCH_WORDS];
   logic [IDX_W-1:0] word_idx;

   // upper offset bits are ignored, so the window repeats
   assign word_idx = IDX_W'(addr_i.map_v.offset[9:1] % `MB_SCRATCH_WORDS);

   always_ff @(posedge clk) begin
      if (cpu_clk_en_i) begin
         if (sel_i && we_i)
            mem[word_idx] <= wdata_i;
         rdata_o <= mem[word_idx];
      end
   end

endmodule

// ==== hdl/cartridge_rom.sv ====
`timescale 1ns/10ps

`include "mainboard_config.svh"

module cartridge_rom
   import bus_pkg::*;
   import mem_pkg::*;
(
   input  logic                     clk,
   input  logic                     reset_i,
   input  logic                     cpu_clk_en_i,
   input  logic                     bank_wr_i,
   input  logic [`MB_BANK_BITS-1:0] bank_i,
   input  byte_bus_t                byte_i,
   output logic [7:0]               rdata_o,
   input  logic                     load_i,
   input  crom_load_t               load_data_i,
   output logic [`MB_BANK_BITS-1:0] bank_o
);

   localparam int OFF_W = $clog2(`MB_CROM_BYTES);
   localparam int MEM_W = `MB_BANK_BITS + OFF_W;

   logic [7:0]               mem [`MB_CROM_BANKS * `MB_CROM_BYTES];
   logic [`MB_BANK_BITS-1:0] bank_q;
   cpu_addr_u                byte_addr;
   logic [MEM_W-1:0]         rd_idx;
   logic [MEM_W-1:0]         ld_idx;

   assign byte_addr = byte_i.addr;
   assign rd_idx    = {bank_q, byte_addr.map_v.offset[OFF_W-1:0]};  // low offset bits only
   assign ld_idx    = {load_data_i.bank[`MB_BANK_BITS-1:0], OFF_W'(load_data_i.offset)};

   always_ff @(posedge clk) begin
      if (reset_i)
         bank_q <= '0;
      else if (cpu_clk_en_i && bank_wr_i)
         bank_q <= bank_i;
   end

   always_ff @(posedge clk) begin
      if (load_i)
         mem[ld_idx] <= load_data_i.data;  // load wins over a read
      else if (byte_i.strobe)
         rdata_o <= mem[rd_idx];
   end

   assign bank_o = bank_q;

   a_load_bank: assert property (@(posedge clk) disable iff (reset_i)
      load_i |-> (load_data_i.bank < `MB_CROM_BANKS));

endmodule

// ==== hdl/mainboard.sv ====
`timescale 1ns/10ps

`include "mainboard_config.svh"

module mainboard
   import bus_pkg::*;
   import mem_pkg::*;
(
   input  logic                     clk,
   input  logic                     reset_i,
   input  cpu_bus_t                 cpu_bus_i,
   output logic [15:0]              d_o,
   output logic                     ready_o,
   output logic                     cpu_clk_en_o,
   input  logic                     load_i,
   input  crom_load_t               load_data_i,
   output logic [`MB_BANK_BITS-1:0] bank_o
);

   dev_sel_t                 dev_sel;
   region_e                  region;
   region_e                  region_q;
   logic [`MB_BANK_BITS-1:0] bank_sel;
   byte_bus_t                mux_byte;
   logic [7:0]               crom_rdata;
   logic [15:0]              mux_word;
   logic                     word_valid;
   logic [15:0]              sp_rdata;

   clk_enable_gen clk_en_gen (
      .clk          (clk),
      .reset_i      (reset_i),
      .cpu_clk_en_o (cpu_clk_en_o)
   );

   address_decoder addr_dec (
      .cpu_bus_i (cpu_bus_i),
      .sel_o     (dev_sel),
      .region_o  (region),
      .bank_o    (bank_sel)
   );

   bus_multiplexer mpx (
      .clk          (clk),
      .reset_i      (reset_i),
      .cpu_clk_en_i (cpu_clk_en_o),
      .memen_i      (cpu_bus_i.memen),
      .region_i     (region),
      .addr_i       (cpu_bus_i.addr),
      .byte_o       (mux_byte),
      .byte_data_i  (crom_rdata),
      .word_o       (mux_word),
      .word_valid_o (word_valid),
      .ready_o      (ready_o)
   );

   scratchpad_ram ram (
      .clk          (clk),
      .cpu_clk_en_i (cpu_clk_en_o),
      .sel_i        (dev_sel.scratch),
      .we_i         (cpu_bus_i.we),
      .addr_i       (cpu_bus_i.addr),
      .wdata_i      (cpu_bus_i.wdata),
      .rdata_o      (sp_rdata)
   );

   cartridge_rom crom (
      .clk          (clk),
      .reset_i      (reset_i),
      .cpu_clk_en_i (cpu_clk_en_o),
      .bank_wr_i    (dev_sel.bank_wr),
      .bank_i       (bank_sel),
      .byte_i       (mux_byte),
      .rdata_o      (crom_rdata),
      .load_i       (load_i),
      .load_data_i  (load_data_i),
      .bank_o       (bank_o)
   );

   // address is held for the whole access, so every enable sees the same region
   always_ff @(posedge clk) begin
      if (reset_i)
         region_q <= REG_NONE;
      else if (cpu_clk_en_o && cpu_bus_i.memen)
         region_q <= region;
   end

   always_comb begin
      d_o = '0;
      if (ready_o) begin
         case (region_q)
            REG_SCRATCH: d_o = sp_rdata;
            REG_CART:    d_o = word_valid ? mux_word : 16'h0000;
            default:     d_o = '0;  // unmapped reads as zero
         endcase
      end
   end

   // byte cycles belong to a cartridge read still held by the cpu
   a_strobe_cart: assert property (@(posedge clk) disable iff (reset_i)
      mux_byte.strobe |-> dev_sel.cart);

endmodule

// ==== tests/mainboard_tb.sv ====
`timescale 1ns/10ps

`include "mainboard_config.svh"

module mainboard_tb
   import bus_pkg::*;
   import mem_pkg::*;
();

   localparam int    MAX_PATS = 64;
   localparam string PAT_FILE = "tests/mainboard_patterns.txt";

   logic                     clk = 1'b0;
   logic                     reset_i;
   cpu_bus_t                 cpu_bus;
   logic [15:0]              rdata;
   logic                     ready;
   logic                     cpu_clk_en;
   logic                     load;
   crom_load_t               load_data;
   logic [`MB_BANK_BITS-1:0] bank;

   logic [15:0] pat_mem [4*MAX_PATS];  // op, addr, data, expected word per pattern
   int          num_pats;
   int          errors;
   int          checks;
   int          cycles;
   int          cycle_limit;
   logic [31:0] lfsr;

   mainboard uut (
      .clk          (clk),
      .reset_i      (reset_i),
      .cpu_bus_i    (cpu_bus),
      .d_o          (rdata),
      .ready_o      (ready),
      .cpu_clk_en_o (cpu_clk_en),
      .load_i       (load),
      .load_data_i  (load_data),
      .bank_o       (bank)
   );

   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycles++;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("checks: %0d, errors: %0d", checks, errors);
         $display("*** FAILED ***");
         $finish;
      end
   end

   // galois form, taps for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'h8020_0003;
      return s >> 1;
   endfunction

   task automatic take_bits(input int nbits, output int val);
      val = 0;
      for (int i = 0; i < nbits; i++) begin
         lfsr = lfsr_next(lfsr);
         val  = {val[30:0], lfsr[0]};
      end
   endtask

   task automatic check_word(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      checks++;
      assert (got == exp) else begin
         errors++;
         $display("** Error: %s = %0h, expected %0h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      checks++;
      assert (cond) else begin
         errors++;
         $display("error at %0t: %s", $time, what);
      end
   endtask

   // first enable after reset, then pulse width and spacing
   task automatic check_enable_timing();
      int n;
      int last;
      n = 0;
      while (!cpu_clk_en && n < 4 * `MB_CPU_CLK_DIV) begin
         @(negedge clk);
         n++;
      end
      check_count("cpu_clk_en_o first pulse delay", n, `MB_CPU_CLK_DIV);
      repeat (3) begin
         last = n;
         @(negedge clk);
         n++;
         check_true(!cpu_clk_en, "cpu_clk_en_o stayed high for two clocks");
         while (!cpu_clk_en && n < last + 4 * `MB_CPU_CLK_DIV) begin
            @(negedge clk);
            n++;
         end
         check_count("cpu_clk_en_o pulse spacing", n - last, `MB_CPU_CLK_DIV);
      end
   endtask

   task automatic do_load(input logic [15:0] field, input logic [15:0] data);
      load             = 1'b1;
      load_data.bank   = field[13:8];  // bank in the high byte
      load_data.offset = field[7:0];
      load_data.data   = data[7:0];
      @(negedge clk);
      load      = 1'b0;
      load_data = '0;
      check_true(!ready, "ready_o pulsed during a cartridge load");
   endtask

   task automatic do_access(input logic write, input logic [15:0] addr,
                            input logic [15:0] wdata, input logic [15:0] exp_word);
      cpu_addr_u   a;
      logic        is_cart;
      int          latency;
      int          n;
      int          start;
      logic [15:0] got;
      a       = addr;
      is_cart = !write && (a.map_v.region == 3'd3);
      latency = is_cart ? 2 * `MB_CPU_CLK_DIV + 1 : 1;  // third enable plus one
      cpu_bus.memen = 1'b1;
      cpu_bus.we    = write;
      cpu_bus.addr  = a;
      cpu_bus.wdata = wdata;
      n     = 0;
      start = cpu_clk_en ? 0 : -1;
      while (!ready) begin
         @(negedge clk);
         n++;
         if (start < 0 && cpu_clk_en && !ready)
            start = n;
      end
      got = rdata;
      check_count("ready_o latency", n - start, latency);
      if (!write)
         check_word("d_o", got, exp_word);
      if (write && a.map_v.region == 3'd3)
         check_word("bank_o", 16'(bank), 16'(addr[6:1] % `MB_CROM_BANKS));
      cpu_bus = '0;  // cpu lets go in the ready cycle
      @(negedge clk);
      check_true(!ready, "ready_o pulse lasted more than one clock");
   endtask

   task automatic idle_gap();
      int gap;
      take_bits(2, gap);
      repeat (gap) @(negedge clk);
   endtask

   initial begin
      reset_i     = 1'b1;
      cpu_bus     = '0;
      load        = 1'b0;
      load_data   = '0;
      errors      = 0;
      checks      = 0;
      cycles      = 0;
      cycle_limit = 0;
      lfsr        = 32'h12de;

      for (int i = 0; i < 4 * MAX_PATS; i++)
         pat_mem[i] = 16'hffff;
      $readmemh(PAT_FILE, pat_mem);
      num_pats = 0;
      while (num_pats < MAX_PATS && pat_mem[4*num_pats] != 16'hffff)
         num_pats++;
      check_true(num_pats > 0, "no patterns found in the pattern file");
      cycle_limit = num_pats * 4 * `MB_CPU_CLK_DIV + 200;

      repeat (8) @(negedge clk);
      reset_i = 1'b0;
      check_true(!ready, "ready_o high after reset");
      check_word("bank_o", 16'(bank), 16'h0000);
      check_true(!cpu_clk_en, "cpu_clk_en_o high right after reset");
      check_enable_timing();

      for (int k = 0; k < num_pats; k++) begin
         case (pat_mem[4*k])
            16'h0000: do_access(1'b0, pat_mem[4*k+1], pat_mem[4*k+2], pat_mem[4*k+3]);
            16'h0001: do_access(1'b1, pat_mem[4*k+1], pat_mem[4*k+2], pat_mem[4*k+3]);
            16'h0002: do_load(pat_mem[4*k+1], pat_mem[4*k+2]);
            default:  check_true(1'b0, "unknown operation code in the pattern file");
         endcase
         idle_gap();
      end

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

// ==== tests/mainboard_patterns.txt ====
// columns: op addr data expected, all hex; op 0 read, 1 write, 2 load
// a load holds the bank in the high byte of addr and the offset in the low byte
0002 0020 00a5 0000
0002 0021 005a 0000
0002 0220 003c 0000
0002 0221 00c3 0000
0002 0140 0077 0000
0002 0141 0088 0000
0001 8010 1234 0000
0000 8010 0000 1234
0000 8110 0000 1234
0001 807e beef 0000
0000 817e 0000 beef
0000 6020 0000 a55a
0001 600c 0000 0000
0000 6020 0000 3cc3
0000 6120 0000 3cc3
0001 6042 0000 0000
0000 6040 0000 7788
0001 6000 0000 0000
0000 6020 0000 a55a
0000 0000 0000 0000
0000 8400 0000 0000
0000 a000 0000 0000

// ==== list.f ====
+incdir+include
hdl/bus_pkg.sv
hdl/mem_pkg.sv
hdl/clk_enable_gen.sv
hdl/address_decoder.sv
hdl/bus_multiplexer.sv
hdl/scratchpad_ram.sv
hdl/cartridge_rom.sv
hdl/mainboard.sv
tests/mainboard_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       := mainboard_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -F -q '*** FAILED ***' $(LOG); then exit 1; fi
	@if ! grep -F -q '*** PASSED ***' $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
